// ==== common/shader_consts.svh ====
//--------------------------------------
// All fixed values carry 14 fraction bits
// Normalized values must stay within +/-1.0
//--------------------------------------
`ifndef SHADER_CONSTS_SVH
`define SHADER_CONSTS_SVH

// Fixed-point layout
`define FIXED_FRAC_WIDTH 14
`define FIXED_NORM_WIDTH 16
`define FIXED_WIDTH 32

// 0.3 in normalized fixed form
`define AMBIENT_LEVEL 4915

// Integer far limit of a reflection ray
`define RAY_MAX_T 1000

// Bounce counter width, also sets the divider length
`define BOUNCE_WIDTH 8

`endif

// ==== common/shaderPkg.sv ====
//--------------------------------------
// Shared types of the shading stage
// Field order inside each struct is MSB first
//--------------------------------------
`default_nettype none
`include "shader_consts.svh"

package shaderPkg;

    //--------------------------------------
    // Fixed-point types
    //--------------------------------------
    typedef logic signed [`FIXED_NORM_WIDTH-1:0] fixedNormT;
    typedef logic signed [`FIXED_WIDTH-1:0] fixedT;

    typedef struct packed {
        fixedNormT x;
        fixedNormT y;
        fixedNormT z;
    } fixedNorm3T;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } fixed3T;

    //--------------------------------------
    // Color types
    //--------------------------------------
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    // Per-channel 16-bit sums, index 2 is red
    typedef logic [2:0][15:0] colorAccumT;

    typedef enum logic [1:0] {
        surfNone,
        surfDiffuse,
        surfMetal,
        surfDielectric
    } surfaceT;

    typedef enum logic [1:0] {
        stIdle,
        stDivide,
        stFragDone,
        stRayDone
    } shaderStateT;

    //--------------------------------------
    // Records
    //--------------------------------------
    typedef struct packed {
        logic [`BOUNCE_WIDTH-1:0] maxBounce;
        fixedNorm3T lightDir;
    } renderStateT;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        fixed3T hitPos;
        fixedNorm3T normal;
        fixed3T viewDir;
        rgb8T color;
        rgb8T lastColor;
        logic [`BOUNCE_WIDTH-1:0] bounceLevel;
        surfaceT surface;
        logic shadow;
    } fragInT;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        rgb8T color;
    } fragOutT;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        rgb8T lastColor;
        logic [`BOUNCE_WIDTH-1:0] bounceLevel;
        fixed3T orig;
        fixed3T dir;
        fixedT minT;
        fixedT maxT;
    } rayOutT;

endpackage

`default_nettype wire

// ==== lighting/diffuseLighting.sv ====
//--------------------------------------
// Light and normal must be unit length
// Output is clamped to the range 0.3 .. 1.0
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module diffuseLighting import shaderPkg::*; (
    input  fixedNorm3T lightDir,
    input  fixedNorm3T normal,
    input  logic       hit,
    input  logic       shadow,
    output fixedNormT  light
);

    localparam fixedNormT lightOne = fixedNormT'(1 << `FIXED_FRAC_WIDTH);

    logic signed [33:0] dotSum;
    logic signed [33:0] dotVal;
    logic signed [33:0] lambert;
    logic signed [33:0] total;

    always_comb begin
        // Full-precision dot product, then drop the fraction
        dotSum = lightDir.x * normal.x + lightDir.y * normal.y + lightDir.z * normal.z;
        dotVal = dotSum >>> `FIXED_FRAC_WIDTH;

        // Back-facing or shadowed surfaces get no direct light
        lambert = (shadow || dotVal < 0) ? '0 : dotVal;
        total = lambert + `AMBIENT_LEVEL;

        // A miss shows the sky color unchanged
        if (!hit || total > lightOne) begin
            light = lightOne;
        end else begin
            light = fixedNormT'(total);
        end
    end

endmodule

`default_nettype wire

// ==== lighting/surfaceColor.sv ====
//--------------------------------------
// Light term must be non-negative
// Sums are not yet divided by the bounce count
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module surfaceColor import shaderPkg::*; (
    input  surfaceT                  surface,
    input  fixedNormT                light,
    input  rgb8T                     color,
    input  rgb8T                     lastColor,
    input  logic [`BOUNCE_WIDTH-1:0] bounceLevel,
    output colorAccumT               accum
);

    fixedNormT lightEff;
    logic [2:0][7:0] colorCh;
    logic [2:0][7:0] lastCh;
    logic [2:0][23:0] litProd;
    logic [2:0][7:0] litCh;

    assign colorCh = color;
    assign lastCh = lastColor;

    always_comb begin
        // Metal keeps only a quarter of its own lighting
        if (surface == surfMetal) begin
            lightEff = light >>> 2;
        end else begin
            lightEff = light;
        end

        for (int ch = 0; ch < 3; ch++) begin
            litProd[ch] = lightEff[15:0] * colorCh[ch];
            litCh[ch] = litProd[ch][`FIXED_FRAC_WIDTH +: 8];
            // Earlier bounces weighted by how many there were
            accum[ch] = lastCh[ch] * bounceLevel + 16'(litCh[ch]);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/colorDivider.sv ====
//--------------------------------------
// done pulses 16 cycles after start
// Quotient must fit in 8 bits, divisor nonzero
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module colorDivider import shaderPkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  colorAccumT               dividend,
    input  logic [`BOUNCE_WIDTH-1:0] divisor,
    output logic                     done,
    output rgb8T                     quotient
);

    // One quotient bit per dividend bit
    localparam int steps = `BOUNCE_WIDTH + 8;

    logic busy;
    logic [3:0] stepCnt;
    logic [`BOUNCE_WIDTH-1:0] divisorReg;
    logic [2:0][7:0] remReg;
    logic [2:0][15:0] quoReg;

    // Restoring step, returns {remainder, shifted quotient}
    function automatic logic [23:0] divStep(
        input logic [7:0] rem,
        input logic [15:0] quo,
        input logic [7:0] dvs
    );
        logic [8:0] remShift;
        logic [9:0] trial;
        remShift = {rem, quo[15]};
        trial = {1'b0, remShift} - {2'b00, dvs};
        if (!trial[9]) begin
            return {trial[7:0], quo[14:0], 1'b1};
        end
        return {remShift[7:0], quo[14:0], 1'b0};
    endfunction

    //--------------------------------------
    // Control
    //--------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            stepCnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // First step already happens on the start edge
                busy <= 1'b1;
                stepCnt <= 4'(steps - 1);
            end else if (busy) begin
                stepCnt <= stepCnt - 1'b1;
                if (stepCnt == 4'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    //--------------------------------------
    // Datapath, all channels in lockstep
    //--------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            divisorReg <= divisor;
            for (int ch = 0; ch < 3; ch++) begin
                {remReg[ch], quoReg[ch]} <= divStep(8'd0, dividend[ch], divisor);
            end
        end else if (busy) begin
            for (int ch = 0; ch < 3; ch++) begin
                {remReg[ch], quoReg[ch]} <= divStep(remReg[ch], quoReg[ch], divisorReg);
            end
        end
    end

    assign quotient = {quoReg[2][7:0], quoReg[1][7:0], quoReg[0][7:0]};

endmodule

`default_nettype wire

// ==== rtl/reflectDir.sv ====
//--------------------------------------
// Normal must be unit length
// Products are truncated toward minus infinity
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module reflectDir import shaderPkg::*; (
    input  fixedNorm3T normal,
    input  fixed3T     viewDir,
    output fixed3T     dir
);

    fixed3T nWide;
    fixedT dotNI;
    fixedT dotTwice;

    // Fixed multiply with the fraction shifted back out
    function automatic fixedT fixMul(input fixedT a, input fixedT b);
        logic signed [2*`FIXED_WIDTH-1:0] prod;
        prod = a * b;
        return prod[`FIXED_FRAC_WIDTH +: `FIXED_WIDTH];
    endfunction

    always_comb begin
        nWide.x = fixedT'(normal.x);
        nWide.y = fixedT'(normal.y);
        nWide.z = fixedT'(normal.z);

        dotNI = fixMul(nWide.x, viewDir.x) + fixMul(nWide.y, viewDir.y)
              + fixMul(nWide.z, viewDir.z);
        dotTwice = dotNI <<< 1;

        // R = I - 2(N.I)N
        dir.x = viewDir.x - fixMul(dotTwice, nWide.x);
        dir.y = viewDir.y - fixMul(dotTwice, nWide.y);
        dir.z = viewDir.z - fixMul(dotTwice, nWide.z);
    end

endmodule

`default_nettype wire

// ==== rtl/shader.sv ====
//--------------------------------------
// renderState must hold steady per fragment
// Dielectric surfaces shade as diffuse
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module shader import shaderPkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inValid,
    output logic        inReady,
    input  fragInT      inFrag,
    input  renderStateT renderState,
    output logic        outValid,
    input  logic        outReady,
    output fragOutT     outFrag,
    output logic        rayValid,
    input  logic        rayReady,
    output rayOutT      rayOut
);

    localparam fixedT rayMaxT = fixedT'(`RAY_MAX_T * (1 << `FIXED_FRAC_WIDTH));

    fragInT slotData;
    fragInT cur;
    logic slotFull;
    shaderStateT state;

    logic divStart;
    logic divDone;
    fixedNormT light;
    colorAccumT accum;
    rgb8T avgColor;
    fixed3T reflDir;
    logic [`BOUNCE_WIDTH-1:0] bounceCount;

    logic acceptIn;
    logic loadCur;
    logic finish;
    logic toRay;

    assign inReady = !slotFull;
    assign acceptIn = inValid && inReady;
    assign loadCur = (state == stIdle) && slotFull;
    assign finish = (state == stDivide) && divDone;
    // Only metal below the bounce limit spawns another ray
    assign toRay = (cur.surface == surfMetal) && (cur.bounceLevel < renderState.maxBounce);
    assign bounceCount = cur.bounceLevel + 1'b1;

    //--------------------------------------
    // Control FSM
    //--------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            slotFull <= 1'b0;
            state <= stIdle;
            divStart <= 1'b0;
            outValid <= 1'b0;
            rayValid <= 1'b0;
        end else begin
            divStart <= 1'b0;
            if (acceptIn) begin
                slotFull <= 1'b1;
            end
            case (state)
                stIdle: begin
                    if (slotFull) begin
                        slotFull <= 1'b0;
                        divStart <= 1'b1;
                        state <= stDivide;
                    end
                end
                stDivide: begin
                    if (divDone && toRay) begin
                        rayValid <= 1'b1;
                        state <= stRayDone;
                    end else if (divDone) begin
                        outValid <= 1'b1;
                        state <= stFragDone;
                    end
                end
                stFragDone: begin
                    if (outReady) begin
                        outValid <= 1'b0;
                        state <= stIdle;
                    end
                end
                stRayDone: begin
                    if (rayReady) begin
                        rayValid <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    //--------------------------------------
    // Slot, current and output registers
    //--------------------------------------
    always_ff @(posedge clk) begin
        if (acceptIn) begin
            slotData <= inFrag;
        end
        if (loadCur) begin
            cur <= slotData;
        end
        if (finish && !toRay) begin
            outFrag.x <= cur.x;
            outFrag.y <= cur.y;
            outFrag.color <= avgColor;
        end
        if (finish && toRay) begin
            rayOut.x <= cur.x;
            rayOut.y <= cur.y;
            rayOut.lastColor <= avgColor;
            rayOut.bounceLevel <= bounceCount;
            rayOut.orig <= cur.hitPos;
            rayOut.dir <= reflDir;
            rayOut.minT <= '0;
            rayOut.maxT <= rayMaxT;
        end
    end

    //--------------------------------------
    // Shading datapath
    //--------------------------------------
    diffuseLighting i_diffuseLighting (
        .lightDir (renderState.lightDir),
        .normal   (cur.normal),
        .hit      (cur.surface != surfNone),
        .shadow   (cur.shadow),
        .light    (light)
    );

    surfaceColor i_surfaceColor (
        .surface     (cur.surface),
        .light       (light),
        .color       (cur.color),
        .lastColor   (cur.lastColor),
        .bounceLevel (cur.bounceLevel),
        .accum       (accum)
    );

    // Average over all bounces so far
    colorDivider i_colorDivider (
        .clk      (clk),
        .resetn   (resetn),
        .start    (divStart),
        .dividend (accum),
        .divisor  (bounceCount),
        .done     (divDone),
        .quotient (avgColor)
    );

    reflectDir i_reflectDir (
        .normal  (cur.normal),
        .viewDir (cur.viewDir),
        .dir     (reflDir)
    );

endmodule

`default_nettype wire

// ==== test/tbShader.sv ====
//--------------------------------------
// Directed tests with a reference model built from the shading rules
// renderState is held at one value for the whole run
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "shader_consts.svh"

module tbShader import shaderPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int numTests = 5;
    localparam int respLimit = 60;

    logic clk;
    logic resetn;
    logic inValid;
    logic inReady;
    fragInT inFrag;
    renderStateT renderState;
    logic outValid;
    logic outReady;
    fragOutT outFrag;
    logic rayValid;
    logic rayReady;
    rayOutT rayOut;

    int errorCount;
    int checkCount;
    logic [31:0] lfsrState;

    shader i_shader (
        .clk         (clk),
        .resetn      (resetn),
        .inValid     (inValid),
        .inReady     (inReady),
        .inFrag      (inFrag),
        .renderState (renderState),
        .outValid    (outValid),
        .outReady    (outReady),
        .outFrag     (outFrag),
        .rayValid    (rayValid),
        .rayReady    (rayReady),
        .rayOut      (rayOut)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //--------------------------------------
    // Random source
    //--------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return val;
    endfunction

    function automatic fragInT makeFrag(input logic [15:0] x, input logic [15:0] y,
            input surfaceT surf, input logic [7:0] level, input logic shadow);
        fragInT f;
        logic [31:0] tmp;
        f = '0;
        f.x = x;
        f.y = y;
        tmp = randBits(14);
        f.normal.x = {{2{tmp[13]}}, tmp[13:0]};
        tmp = randBits(14);
        f.normal.y = {{2{tmp[13]}}, tmp[13:0]};
        // Keeping z between 0.5 and 1.0 turns the surface toward the light
        tmp = randBits(13);
        f.normal.z = {3'b001, tmp[12:0]};
        tmp = randBits(24);
        f.color = tmp[23:0];
        tmp = randBits(24);
        f.lastColor = tmp[23:0];
        f.hitPos.x = 32'sd49152;
        f.hitPos.y = -32'sd20000;
        f.hitPos.z = 32'sd1000000;
        f.viewDir.x = 32'sd8192;
        f.viewDir.y = -32'sd4096;
        f.viewDir.z = -32'sd16384;
        f.bounceLevel = level;
        f.surface = surf;
        f.shadow = shadow;
        return f;
    endfunction

    //--------------------------------------
    // Reference model
    //--------------------------------------
    function automatic int lightModel(input fragInT f);
        longint dot;
        int light;
        dot = longint'(renderState.lightDir.x) * f.normal.x
            + longint'(renderState.lightDir.y) * f.normal.y
            + longint'(renderState.lightDir.z) * f.normal.z;
        dot = dot >>> `FIXED_FRAC_WIDTH;
        if (f.shadow || dot < 0) begin
            light = 0;
        end else begin
            light = int'(dot);
        end
        light = light + `AMBIENT_LEVEL;
        if (f.surface == surfNone || light > (1 << `FIXED_FRAC_WIDTH)) begin
            light = 1 << `FIXED_FRAC_WIDTH;
        end
        return light;
    endfunction

    function automatic logic [7:0] shadeChannel(input int light, input int c,
            input int last, input int level);
        int lit;
        lit = (light * c) / (1 << `FIXED_FRAC_WIDTH);
        return 8'((last * level + lit) / (level + 1));
    endfunction

    function automatic rgb8T colorModel(input fragInT f);
        rgb8T c;
        int light;
        light = lightModel(f);
        if (f.surface == surfMetal) begin
            light = light / 4;
        end
        c.r = shadeChannel(light, f.color.r, f.lastColor.r, f.bounceLevel);
        c.g = shadeChannel(light, f.color.g, f.lastColor.g, f.bounceLevel);
        c.b = shadeChannel(light, f.color.b, f.lastColor.b, f.bounceLevel);
        return c;
    endfunction

    // Product with the fraction dropped by rounding down
    function automatic fixedT mulFix(input longint a, input longint b);
        longint p;
        p = (a * b) >>> `FIXED_FRAC_WIDTH;
        return fixedT'(p);
    endfunction

    function automatic fixed3T reflectModel(input fixedNorm3T n, input fixed3T v);
        fixed3T r;
        fixedT d;
        d = mulFix(n.x, v.x) + mulFix(n.y, v.y) + mulFix(n.z, v.z);
        d = 2 * d;
        r.x = v.x - mulFix(d, n.x);
        r.y = v.y - mulFix(d, n.y);
        r.z = v.z - mulFix(d, n.z);
        return r;
    endfunction

    //--------------------------------------
    // Driving and checking
    //--------------------------------------
    task automatic checkValue(input string name, input logic [127:0] expected,
            input logic [127:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic sendFrag(input fragInT f);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        inValid <= 1'b1;
        inFrag <= f;
        @(negedge clk);
        while (!inReady && waitCnt < respLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!inReady) begin
            errorCount++;
            $display("Input was not accepted within %0d cycles", respLimit);
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // Captures one output and lets its handshake edge pass
    task automatic waitResult(input string testName, input logic expectRay,
            output fragOutT gotFrag, output rayOutT gotRay);
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (!outValid && !rayValid && waitCnt < respLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        if (outValid && rayValid) begin
            errorCount++;
            $display("%s: fragment and ray outputs were valid together", testName);
        end
        if (!outValid && !rayValid) begin
            errorCount++;
            $display("%s: no output appeared within %0d cycles", testName, respLimit);
        end else if (rayValid !== expectRay) begin
            errorCount++;
            $display("%s: wrong kind of output, ray expected = %0b", testName, expectRay);
        end
        gotFrag = outFrag;
        gotRay = rayOut;
        @(posedge clk);
    endtask

    //--------------------------------------
    // Tests
    //--------------------------------------
    task automatic shadeLitDiffuse();
        fragInT f;
        fragOutT got;
        rayOutT ray;
        f = makeFrag(16'd12, 16'd34, surfDiffuse, 8'd0, 1'b0);
        sendFrag(f);
        waitResult("litDiffuse", 1'b0, got, ray);
        checkValue("litDiffuse color", colorModel(f), got.color);
        checkValue("litDiffuse x", f.x, got.x);
        checkValue("litDiffuse y", f.y, got.y);
    endtask

    task automatic shadeShadowAndMiss();
        fragInT f;
        fragOutT got;
        rayOutT ray;
        f = makeFrag(16'd5, 16'd6, surfDiffuse, 8'd0, 1'b1);
        sendFrag(f);
        waitResult("shadow", 1'b0, got, ray);
        checkValue("shadow color", colorModel(f), got.color);
        // A miss lights fully even when flagged as shadowed
        f = makeFrag(16'd7, 16'd8, surfNone, 8'd0, 1'b1);
        sendFrag(f);
        waitResult("miss", 1'b0, got, ray);
        checkValue("miss color", f.color, got.color);
    endtask

    task automatic metalSpawnsRay();
        fragInT f;
        fragOutT got;
        rayOutT ray;
        for (int level = 0; level < 3; level += 2) begin
            f = makeFrag(16'd100 + 16'(level), 16'd200, surfMetal, 8'(level), 1'b0);
            sendFrag(f);
            waitResult("metalRay", 1'b1, got, ray);
            checkValue("metalRay x", f.x, ray.x);
            checkValue("metalRay y", f.y, ray.y);
            checkValue("metalRay dir", reflectModel(f.normal, f.viewDir), ray.dir);
            checkValue("metalRay bounceLevel", 8'(level + 1), ray.bounceLevel);
            checkValue("metalRay lastColor", colorModel(f), ray.lastColor);
            checkValue("metalRay orig", f.hitPos, ray.orig);
            checkValue("metalRay minT", 32'd0, ray.minT);
            checkValue("metalRay maxT", 32'(`RAY_MAX_T * 16384), ray.maxT);
        end
    endtask

    task automatic metalAtBounceLimit();
        fragInT f;
        fragOutT got;
        rayOutT ray;
        for (int level = 3; level < 5; level++) begin
            f = makeFrag(16'd300, 16'd400 + 16'(level), surfMetal, 8'(level), 1'b0);
            sendFrag(f);
            waitResult("metalLimit", 1'b0, got, ray);
            checkValue("metalLimit color", colorModel(f), got.color);
            checkValue("metalLimit y", f.y, got.y);
        end
    endtask

    task automatic backPressureBuffering();
        fragInT fa;
        fragInT fb;
        fragOutT got;
        fragOutT held;
        rayOutT ray;
        int waitCnt;
        fa = makeFrag(16'd1, 16'd2, surfDiffuse, 8'd0, 1'b0);
        fb = makeFrag(16'd3, 16'd4, surfDielectric, 8'd1, 1'b0);
        @(posedge clk);
        outReady <= 1'b0;
        sendFrag(fa);
        sendFrag(fb);
        // Second fragment waits in the slot
        @(negedge clk);
        checkValue("backPressure inReady", 1'b0, inReady);
        waitCnt = 0;
        while (!outValid && waitCnt < respLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        held = outFrag;
        repeat (5) begin
            @(negedge clk);
            checkValue("backPressure outValid held", 1'b1, outValid);
            checkValue("backPressure outFrag stable", held, outFrag);
            checkValue("backPressure inReady held", 1'b0, inReady);
        end
        @(posedge clk);
        outReady <= 1'b1;
        waitResult("backPressure first", 1'b0, got, ray);
        checkValue("backPressure first color", colorModel(fa), got.color);
        checkValue("backPressure first x", fa.x, got.x);
        waitResult("backPressure second", 1'b0, got, ray);
        checkValue("backPressure second color", colorModel(fb), got.color);
        checkValue("backPressure second x", fb.x, got.x);
    endtask

    //--------------------------------------
    // Main sequence
    //--------------------------------------
    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        inValid = 1'b0;
        inFrag = '0;
        outReady = 1'b1;
        rayReady = 1'b1;
        renderState.maxBounce = 8'd3;
        // Unit light direction (0.6, 0, 0.8)
        renderState.lightDir.x = 16'sd9830;
        renderState.lightDir.y = 16'sd0;
        renderState.lightDir.z = 16'sd13107;
        errorCount = 0;
        checkCount = 0;
        lfsrState = 32'h02f38e87;

        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        checkValue("reset inReady", 1'b1, inReady);
        checkValue("reset outValid", 1'b0, outValid);
        checkValue("reset rayValid", 1'b0, rayValid);

        shadeLitDiffuse();
        shadeShadowAndMiss();
        metalSpawnsRay();
        metalAtBounceLimit();
        backPressureBuffering();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(numTests * 200 * clkPeriod);
        $display("Watchdog expired after %0d cycles", numTests * 200);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== shader.f ====
+incdir+common
common/shaderPkg.sv
lighting/diffuseLighting.sv
lighting/surfaceColor.sv
rtl/colorDivider.sv
rtl/reflectDir.sv
rtl/shader.sv
test/tbShader.sv

// ==== Bender.yml ====
package:
  name: shader

sources:
  - include_dirs:
      - common
    files:
      - common/shaderPkg.sv
      - lighting/diffuseLighting.sv
      - lighting/surfaceColor.sv
      - rtl/colorDivider.sv
      - rtl/reflectDir.sv
      - rtl/shader.sv
      - target: test
        files:
          - test/tbShader.sv
